// File: src/trace_pkg.sv
`default_nettype none

package trace_pkg;

  // Data and instruction word width
  localparam int unsigned XLEN = 32;

  // Register number width, 32 architectural registers
  localparam int unsigned REG_IDX_W = 5;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Full 8-bit nop opcode as seen in the nop view
  // Upper 6 bits form the major opcode
  localparam logic [7:0] NOP_OPCODE = 8'h15;

  // Generic view, major opcode in the top 6 bits
  typedef struct packed {
    logic [5:0]  major;
    logic [25:0] rest;
  } insn_op_t;

  // Nop view, command code sits in the low half-word
  typedef struct packed {
    logic [7:0]  nop_op;
    logic [7:0]  rsvd;
    logic [15:0] imm;
  } insn_nop_t;

  // One retired instruction word, decoded either way
  typedef union packed {
    insn_op_t  op;
    insn_nop_t nop;
  } insn_u;

endpackage

`default_nettype wire

// File: src/simctl_pkg.sv
`default_nettype none

package simctl_pkg;

  // Command codes carried in a nop immediate
  // Software picks one, argument goes in the argument register
  typedef enum logic [15:0] {
    NOP_NOP    = 16'h0000,
    NOP_EXIT   = 16'h0001,
    NOP_REPORT = 16'h0002,
    NOP_PUTC   = 16'h0004
  } nop_code_t;

  // Kind of event raised towards the testbench
  typedef enum logic [1:0] {
    EV_NONE   = 2'd0,
    EV_EXIT   = 2'd1,
    EV_REPORT = 2'd2,
    EV_PUTC   = 2'd3
  } event_kind_t;

endpackage

`default_nettype wire

// File: src/reg_shadow.sv
`default_nettype none

module reg_shadow #(
  // Register holding the command argument, 1 to 31
  parameter int unsigned ARG_REG = 3
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         retire_valid_i,
  input  logic                         wb_en_i,
  input  trace_pkg::reg_idx_t          wb_reg_i,
  input  logic [trace_pkg::XLEN-1:0]   wb_data_i,
  output logic [trace_pkg::XLEN-1:0]   arg_value_o
);

  // Shadow copy of registers 1..31
  // Register 0 reads as zero and has no storage
  logic [trace_pkg::XLEN-1:0] shadow_q [1:31];

  // Qualified writeback
  logic wb_fire;

  // Only retired writebacks to a real register count
  assign wb_fire = retire_valid_i && wb_en_i && (wb_reg_i != '0);

  // Register file update
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (wb_fire) begin
      shadow_q[wb_reg_i] <= wb_data_i;
    end
  end

  // Argument sample
  // Nonblocking read takes the value before this edge's write,
  // so it lines up with the instruction retiring at the same edge
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      arg_value_o <= '0;
    end else begin
      arg_value_o <= shadow_q[ARG_REG];
    end
  end

endmodule

`default_nettype wire

// File: src/nop_decoder.sv
`default_nettype none

module nop_decoder (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         retire_valid_i,
  input  logic [trace_pkg::XLEN-1:0]   pc_i,
  input  trace_pkg::insn_u             insn_i,
  output logic                         valid_o,
  output logic                         is_nop_o,
  output simctl_pkg::nop_code_t        code_o,
  output logic [trace_pkg::XLEN-1:0]   pc_o
);

  // Decode results before the register stage
  logic                  major_hit;
  logic                  is_nop;
  simctl_pkg::nop_code_t code;

  // Major opcode picks out the nop class
  assign major_hit = (insn_i.op.major == trace_pkg::NOP_OPCODE[7:2]);

  // Two opcode bits below the major field complete the match
  assign is_nop = major_hit && (insn_i.nop.nop_op[1:0] == trace_pkg::NOP_OPCODE[1:0]);

  // Immediate is the command
  // Unknown values pass through as is
  assign code = is_nop ? simctl_pkg::nop_code_t'(insn_i.nop.imm) : simctl_pkg::NOP_NOP;

  // Control stage
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      is_nop_o <= 1'b0;
    end else begin
      valid_o  <= retire_valid_i;
      is_nop_o <= is_nop;
    end
  end

  // Payload stage qualified by valid_o
  always_ff @(posedge clk) begin
    code_o <= code;
    pc_o   <= pc_i;
  end

endmodule

`default_nettype wire

// File: src/sim_event_unit.sv
`default_nettype none

module sim_event_unit (
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  logic                         valid_i,
  input  logic                         is_nop_i,
  input  simctl_pkg::nop_code_t        code_i,
  input  logic [trace_pkg::XLEN-1:0]   pc_i,
  input  logic [trace_pkg::XLEN-1:0]   arg_value_i,
  output logic                         event_valid_o,
  output simctl_pkg::event_kind_t      event_kind_o,
  output logic [trace_pkg::XLEN-1:0]   event_data_o,
  output logic [trace_pkg::XLEN-1:0]   event_pc_o,
  output logic                         terminated_o,
  output logic [31:0]                  insn_count_o
);

  // Next event, before the output register
  simctl_pkg::event_kind_t    kind;
  logic [trace_pkg::XLEN-1:0] data;

  // Live retire, not yet terminated
  logic active;

  assign active = valid_i && !terminated_o;

  // Map command code to event kind and payload
  always_comb begin
    kind = simctl_pkg::EV_NONE;
    data = arg_value_i;
    if (active && is_nop_i) begin
      case (code_i)
        simctl_pkg::NOP_EXIT: begin
          // Argument is the exit code
          kind = simctl_pkg::EV_EXIT;
        end
        simctl_pkg::NOP_REPORT: begin
          kind = simctl_pkg::EV_REPORT;
        end
        simctl_pkg::NOP_PUTC: begin
          // Character in the low byte only
          kind = simctl_pkg::EV_PUTC;
          data = {{(trace_pkg::XLEN-8){1'b0}}, arg_value_i[7:0]};
        end
        default: begin
          // Plain nop or unknown code, silent
          kind = simctl_pkg::EV_NONE;
        end
      endcase
    end
  end

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      event_valid_o <= 1'b0;
      terminated_o  <= 1'b0;
      insn_count_o  <= '0;
    end else begin
      event_valid_o <= (kind != simctl_pkg::EV_NONE);
      // Sticky until reset
      if (kind == simctl_pkg::EV_EXIT) begin
        terminated_o <= 1'b1;
      end
      // Exit itself still counts, later retires do not
      if (active) begin
        insn_count_o <= insn_count_o + 32'd1;
      end
    end
  end

  // Event payload, meaningful only with event_valid_o
  always_ff @(posedge clk) begin
    event_kind_o <= kind;
    event_data_o <= data;
    event_pc_o   <= pc_i;
  end

endmodule

`default_nettype wire

// File: src/trace_observer.sv
`default_nettype none

module trace_observer #(
  // Register carrying the command argument
  parameter int unsigned ARG_REG = 3
) (
  input  logic                         clk,
  input  logic                         rst_n_i,
  // Retire trace from the core
  input  logic                         retire_valid_i,
  input  logic [trace_pkg::XLEN-1:0]   pc_i,
  input  trace_pkg::insn_u             insn_i,
  input  logic                         wb_en_i,
  input  trace_pkg::reg_idx_t          wb_reg_i,
  input  logic [trace_pkg::XLEN-1:0]   wb_data_i,
  // Simulation events
  output logic                         event_valid_o,
  output simctl_pkg::event_kind_t      event_kind_o,
  output logic [trace_pkg::XLEN-1:0]   event_data_o,
  output logic [trace_pkg::XLEN-1:0]   event_pc_o,
  output logic                         terminated_o,
  output logic [31:0]                  insn_count_o
);

  // Decoder to event unit
  logic                       dec_valid;
  logic                       dec_is_nop;
  simctl_pkg::nop_code_t      dec_code;
  logic [trace_pkg::XLEN-1:0] dec_pc;

  // Shadow to event unit, aligned with the decode stage
  logic [trace_pkg::XLEN-1:0] arg_value;

  reg_shadow #(
    .ARG_REG (ARG_REG)
  ) u_reg_shadow (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .retire_valid_i (retire_valid_i),
    .wb_en_i        (wb_en_i),
    .wb_reg_i       (wb_reg_i),
    .wb_data_i      (wb_data_i),
    .arg_value_o    (arg_value)
  );

  nop_decoder u_nop_decoder (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .retire_valid_i (retire_valid_i),
    .pc_i           (pc_i),
    .insn_i         (insn_i),
    .valid_o        (dec_valid),
    .is_nop_o       (dec_is_nop),
    .code_o         (dec_code),
    .pc_o           (dec_pc)
  );

  sim_event_unit u_sim_event_unit (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .valid_i       (dec_valid),
    .is_nop_i      (dec_is_nop),
    .code_i        (dec_code),
    .pc_i          (dec_pc),
    .arg_value_i   (arg_value),
    .event_valid_o (event_valid_o),
    .event_kind_o  (event_kind_o),
    .event_data_o  (event_data_o),
    .event_pc_o    (event_pc_o),
    .terminated_o  (terminated_o),
    .insn_count_o  (insn_count_o)
  );

endmodule

`default_nettype wire

// File: verif/trace_observer_tb.sv
`default_nettype none

module trace_observer_tb;

  // Argument register used throughout
  localparam int unsigned ARG_REG = 3;
  localparam int MAX_ROWS = 64;

  // One retire slot plus what the observer should show for it
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic [1:0]  exp_kind;
    logic [31:0] exp_data;
    logic [31:0] exp_count;
    logic        exp_term;
  } row_t;

  // DUT inputs
  logic        clk;
  logic        rst_n;
  logic        retire_valid;
  logic [31:0] pc;
  logic [31:0] insn;
  logic        wb_en;
  logic [4:0]  wb_reg;
  logic [31:0] wb_data;

  // DUT outputs
  logic        event_valid;
  logic [1:0]  event_kind;
  logic [31:0] event_data;
  logic [31:0] event_pc;
  logic        terminated;
  logic [31:0] insn_count;

  // Stimulus table, filled before the run
  row_t rows [0:MAX_ROWS-1];
  int   n_rows;
  int   test_first [1:6];
  int   test_last [1:6];

  // Reference model state
  logic [31:0] model_regs [0:31];
  logic [31:0] model_count;
  logic        model_term;

  logic [31:0] lfsr_state = 32'h5c27_afea;

  // Bookkeeping
  int err_count;
  int check_count;
  int test_errs;
  int tests_failed;

  trace_observer #(
    .ARG_REG (ARG_REG)
  ) trace_observer_inst (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .retire_valid_i (retire_valid),
    .pc_i           (pc),
    .insn_i         (insn),
    .wb_en_i        (wb_en),
    .wb_reg_i       (wb_reg),
    .wb_data_i      (wb_data),
    .event_valid_o  (event_valid),
    .event_kind_o   (event_kind),
    .event_data_o   (event_data),
    .event_pc_o     (event_pc),
    .terminated_o   (terminated),
    .insn_count_o   (insn_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // Nop word carrying a command code
  function automatic logic [31:0] nop_insn(input logic [15:0] code);
    return {trace_pkg::NOP_OPCODE, 8'h00, code};
  endfunction

  // Ordinary instruction, random body under the given major opcode
  function automatic logic [31:0] alu_insn(input logic [5:0] major);
    return {major, take_bits(26)};
  endfunction

  task automatic reset_model();
    for (int k = 0; k < 32; k++) begin
      model_regs[k] = '0;
    end
    model_count = '0;
    model_term  = 1'b0;
  endtask

  // Append one row, expected values come from the model
  task automatic add_row(input logic valid, input logic [31:0] insn_w, input logic wb_en_w,
                         input logic [4:0] reg_w, input logic [31:0] data_w);
    row_t        r;
    logic [31:0] arg;
    r.valid   = valid;
    r.pc      = 32'h0000_1000 + 32'(4 * n_rows);
    r.insn    = insn_w;
    r.wb_en   = wb_en_w;
    r.wb_reg  = reg_w;
    r.wb_data = data_w;
    // Command sees the argument before this slot's own write
    arg = model_regs[ARG_REG];
    r.exp_kind = simctl_pkg::EV_NONE;
    r.exp_data = '0;
    if (valid && !model_term && insn_w[31:24] == trace_pkg::NOP_OPCODE) begin
      case (insn_w[15:0])
        simctl_pkg::NOP_EXIT: begin
          r.exp_kind = simctl_pkg::EV_EXIT;
          r.exp_data = arg;
        end
        simctl_pkg::NOP_REPORT: begin
          r.exp_kind = simctl_pkg::EV_REPORT;
          r.exp_data = arg;
        end
        simctl_pkg::NOP_PUTC: begin
          r.exp_kind = simctl_pkg::EV_PUTC;
          r.exp_data = {24'h0, arg[7:0]};
        end
        default: begin
          r.exp_kind = simctl_pkg::EV_NONE;
        end
      endcase
    end
    // Exit still counts, then everything freezes
    if (valid && !model_term) begin
      model_count = model_count + 32'd1;
    end
    if (r.exp_kind == simctl_pkg::EV_EXIT) begin
      model_term = 1'b1;
    end
    if (valid && wb_en_w && reg_w != 5'd0) begin
      model_regs[reg_w] = data_w;
    end
    r.exp_count = model_count;
    r.exp_term  = model_term;
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic add_wb(input logic [4:0] reg_w, input logic [31:0] data_w);
    add_row(1'b1, alu_insn(6'h08), 1'b1, reg_w, data_w);
  endtask

  task automatic add_nop(input logic [15:0] code);
    add_row(1'b1, nop_insn(code), 1'b0, 5'd0, 32'h0);
  endtask

  // Idle slot, junk on the other trace lines
  task automatic add_gap();
    add_row(1'b0, take_bits(32), 1'b0, 5'd0, take_bits(32));
  endtask

  task automatic build_table();
    logic [4:0] other_reg;
    other_reg = 5'((ARG_REG % 31) + 1);
    // Report after writeback
    test_first[1] = n_rows;
    add_wb(5'(ARG_REG), take_bits(32));
    add_nop(simctl_pkg::NOP_REPORT);
    add_gap();
    add_nop(simctl_pkg::NOP_REPORT);
    test_last[1] = n_rows - 1;
    // Putc, low byte only, back to back
    test_first[2] = n_rows;
    add_wb(5'(ARG_REG), take_bits(32));
    add_nop(simctl_pkg::NOP_PUTC);
    add_wb(5'(ARG_REG), take_bits(32));
    add_nop(simctl_pkg::NOP_PUTC);
    add_nop(simctl_pkg::NOP_PUTC);
    add_wb(5'(ARG_REG), 32'h0000_0041);
    add_nop(simctl_pkg::NOP_PUTC);
    test_last[2] = n_rows - 1;
    // Writebacks that must not reach the argument
    test_first[3] = n_rows;
    add_wb(5'(ARG_REG), take_bits(32));
    add_wb(other_reg, take_bits(32));
    add_wb(5'd0, take_bits(32));
    add_row(1'b0, alu_insn(6'h08), 1'b1, 5'(ARG_REG), take_bits(32));
    add_row(1'b1, alu_insn(6'h08), 1'b0, 5'(ARG_REG), take_bits(32));
    add_nop(simctl_pkg::NOP_REPORT);
    test_last[3] = n_rows - 1;
    // Silent instructions still count, idle slots do not
    test_first[4] = n_rows;
    add_row(1'b1, alu_insn(6'h3f), 1'b0, 5'd0, 32'h0);
    add_gap();
    add_gap();
    add_nop(16'h0008);
    add_nop(simctl_pkg::NOP_NOP);
    // Same major opcode, wrong full opcode
    add_row(1'b1, {8'h14, 8'h00, 16'h0002}, 1'b0, 5'd0, 32'h0);
    add_row(1'b1, alu_insn(6'h00), 1'b0, 5'd0, 32'h0);
    add_gap();
    test_last[4] = n_rows - 1;
    // Exit, then nothing more
    test_first[5] = n_rows;
    add_wb(5'(ARG_REG), take_bits(32));
    add_nop(simctl_pkg::NOP_EXIT);
    add_nop(simctl_pkg::NOP_REPORT);
    add_wb(5'(ARG_REG), take_bits(32));
    add_nop(simctl_pkg::NOP_PUTC);
    add_nop(simctl_pkg::NOP_EXIT);
    add_row(1'b1, alu_insn(6'h08), 1'b0, 5'd0, 32'h0);
    test_last[5] = n_rows - 1;
    // Fresh start after reset, shadow back to zero
    reset_model();
    test_first[6] = n_rows;
    add_nop(simctl_pkg::NOP_REPORT);
    add_row(1'b1, alu_insn(6'h08), 1'b0, 5'd0, 32'h0);
    add_wb(5'(ARG_REG), take_bits(32));
    add_nop(simctl_pkg::NOP_PUTC);
    test_last[6] = n_rows - 1;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_row(input int j);
    row_t r;
    logic hit;
    r = rows[j];
    hit = (r.exp_kind != simctl_pkg::EV_NONE);
    check_value($sformatf("row %0d event_valid_o", j), 32'(event_valid), 32'(hit));
    if (hit) begin
      check_value($sformatf("row %0d event_kind_o", j), 32'(event_kind), 32'(r.exp_kind));
      check_value($sformatf("row %0d event_data_o", j), event_data, r.exp_data);
      check_value($sformatf("row %0d event_pc_o", j), event_pc, r.pc);
    end
    check_value($sformatf("row %0d terminated_o", j), 32'(terminated), 32'(r.exp_term));
    check_value($sformatf("row %0d insn_count_o", j), insn_count, r.exp_count);
  endtask

  // Drive on the rising edge, check at the falling edge two slots later
  task automatic apply_rows(input int first, input int last);
    for (int i = first; i <= last + 2; i++) begin
      @(posedge clk);
      if (i <= last) begin
        retire_valid <= rows[i].valid;
        pc           <= rows[i].pc;
        insn         <= rows[i].insn;
        wb_en        <= rows[i].wb_en;
        wb_reg       <= rows[i].wb_reg;
        wb_data      <= rows[i].wb_data;
      end else begin
        retire_valid <= 1'b0;
        wb_en        <= 1'b0;
      end
      @(negedge clk);
      if (i >= first + 2) begin
        check_row(i - 2);
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n        <= 1'b0;
    retire_valid <= 1'b0;
    wb_en        <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_terminated(input int limit);
    int k;
    k = 0;
    while (!terminated && k < limit) begin
      @(negedge clk);
      k++;
    end
    if (!terminated) begin
      err_count++;
      $display("terminated_o did not rise within %0d cycles", limit);
    end
  endtask

  task automatic report_test(input int id, input string name);
    int errs;
    errs = err_count - test_errs;
    if (errs == 0) begin
      $display("test %0d %s: ok", id, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", id, name, errs);
    end
    test_errs = err_count;
  endtask

  initial begin
    rst_n        <= 1'b0;
    retire_valid <= 1'b0;
    pc           <= '0;
    insn         <= '0;
    wb_en        <= 1'b0;
    wb_reg       <= '0;
    wb_data      <= '0;
    err_count    = 0;
    check_count  = 0;
    test_errs    = 0;
    tests_failed = 0;
    n_rows       = 0;
    reset_model();
    build_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    apply_rows(test_first[1], test_last[1]);
    report_test(1, "report after writeback");
    apply_rows(test_first[2], test_last[2]);
    report_test(2, "putc low byte");
    apply_rows(test_first[3], test_last[3]);
    report_test(3, "ignored writebacks");
    apply_rows(test_first[4], test_last[4]);
    report_test(4, "silent retires");
    apply_rows(test_first[5], test_last[5]);
    wait_terminated(16);
    report_test(5, "exit and freeze");

    // Reset mid run, outputs must come back clean
    apply_reset();
    @(negedge clk);
    check_value("post-reset event_valid_o", 32'(event_valid), 32'h0);
    check_value("post-reset terminated_o", 32'(terminated), 32'h0);
    check_value("post-reset insn_count_o", insn_count, 32'h0);
    apply_rows(test_first[6], test_last[6]);
    report_test(6, "reset restart");

    $display("summary: 6 tests, %0d failed, %0d checks, %0d errors",
             tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
src/trace_pkg.sv
src/simctl_pkg.sv
src/reg_shadow.sv
src/nop_decoder.sv
src/sim_event_unit.sv
src/trace_observer.sv
verif/trace_observer_tb.sv
